// File: hdl/gear_cfg_pkg.sv
/*
 * Gearbox configuration
 * Bus geometry, size-mode encoding and the per-mode beat width
 */

`default_nettype none

package gear_cfg_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus geometry
	//////////////////////////////////////////////////////////////////////

	// Bytes in one bus word
	localparam int BUS_BYTES = 8;
	// Bus word width in bits
	localparam int BUS_WIDTH = BUS_BYTES * 8;
	// Byte count 0..8 needs four bits
	localparam int BYTES_W = 4;

	//////////////////////////////////////////////////////////////////////
	// Size modes
	//////////////////////////////////////////////////////////////////////

	// Output beat width select, held for a whole packet
	typedef enum logic [1:0] {
		SZ_BUS  = 2'd0,
		SZ_32B  = 2'd1,
		SZ_16B  = 2'd2,
		SZ_BYTE = 2'd3
	} gear_size_t;

	// Bytes carried by a full beat in the given mode
	function automatic logic [BYTES_W-1:0] step_bytes(input gear_size_t size);
		logic [BYTES_W-1:0] step;
		case (size)
			SZ_BYTE: step = BYTES_W'(1);
			SZ_16B:  step = BYTES_W'(2);
			SZ_32B:  step = BYTES_W'(4);
			default: step = BYTES_W'(BUS_BYTES);
		endcase
		return step;
	endfunction

endpackage

`default_nettype wire

// File: hdl/gear_stream_pkg.sv
/*
 * Gearbox stream beat
 * One word of the valid/ready stream on either side
 */

`default_nettype none

package gear_stream_pkg;

	// Payload of a single stream beat
	// Valid bytes sit at the top of data, first byte highest
	typedef struct packed {
		// Bus word
		logic [gear_cfg_pkg::BUS_WIDTH-1:0] data;
		// Count of valid bytes, 1..8 on a valid beat
		logic [gear_cfg_pkg::BYTES_W-1:0] bytes;
		// Final beat of the packet
		logic last;
	} gear_beat_t;

endpackage

`default_nettype wire

// File: hdl/gear_shift_reg.sv
/*
 * Gearbox shift register
 * Holds the current bus word and shifts sent bytes off the top
 */

`timescale 1ns/1ps
`default_nettype none

module gear_shift_reg (
	input  wire logic                                i_clk,
	input  wire logic                                i_reset,
	input  wire logic                                i_soft_reset,
	input  wire gear_cfg_pkg::gear_size_t            i_size,
	input  wire logic                                i_load,
	input  wire logic                                i_shift,
	input  wire logic                                i_clear,
	input  wire logic [gear_cfg_pkg::BUS_WIDTH-1:0]  i_data,
	input  wire logic [gear_cfg_pkg::BYTES_W-1:0]    i_bytes,
	output logic      [gear_cfg_pkg::BUS_WIDTH-1:0]  o_data,
	output logic      [gear_cfg_pkg::BYTES_W-1:0]    o_fill
);

	// Bytes per beat and the matching bit shift
	logic [gear_cfg_pkg::BYTES_W-1:0] step;
	logic [gear_cfg_pkg::BYTES_W+2:0] step_bits;

	// Word being sent and bytes still unsent
	logic [gear_cfg_pkg::BUS_WIDTH-1:0] sreg;
	logic [gear_cfg_pkg::BYTES_W-1:0] fill;

	assign step = gear_cfg_pkg::step_bytes(i_size);
	assign step_bits = {step, 3'b000};

	//////////////////////////////////////////////////////////////////////
	// Data path
	//////////////////////////////////////////////////////////////////////

	// Big-endian, so the next byte moves up into the top lane
	always_ff @(posedge i_clk)
	begin
		if (i_load)
			sreg <= i_data;
		else if (i_shift)
			sreg <= sreg << step_bits;
	end

	//////////////////////////////////////////////////////////////////////
	// Fill count
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_reset || i_soft_reset)
			fill <= '0;
		else if (i_load)
			fill <= i_bytes;
		// Last beat of packet gone
		else if (i_clear)
			fill <= '0;
		else if (i_shift)
		begin
			// Whole word leaves at once, partial or not
			if (i_size == gear_cfg_pkg::SZ_BUS)
				fill <= '0;
			else
				fill <= fill - step;
		end
	end

	assign o_data = sreg;
	assign o_fill = fill;

endmodule

`default_nettype wire

// File: hdl/gear_beat_ctrl.sv
/*
 * Gearbox beat controller
 * Sizes and flags each output beat, paces the input side and
 * steers the shift register
 */

`timescale 1ns/1ps
`default_nettype none

module gear_beat_ctrl (
	input  wire logic                              i_clk,
	input  wire logic                              i_reset,
	input  wire logic                              i_soft_reset,
	input  wire gear_cfg_pkg::gear_size_t          i_size,
	input  wire logic                              i_s_valid,
	input  wire logic [gear_cfg_pkg::BYTES_W-1:0]  i_s_bytes,
	input  wire logic                              i_s_last,
	input  wire logic                              i_m_ready,
	input  wire logic [gear_cfg_pkg::BYTES_W-1:0]  i_fill,
	output logic                                   o_s_ready,
	output logic                                   o_m_valid,
	output logic      [gear_cfg_pkg::BYTES_W-1:0]  o_m_bytes,
	output logic                                   o_m_last,
	output logic                                   o_load,
	output logic                                   o_shift,
	output logic                                   o_clear
);

	localparam int BW = gear_cfg_pkg::BYTES_W;

	// Beat state
	logic m_valid;
	logic [BW-1:0] m_bytes;
	logic m_last;
	// Final word of packet, more beats after the current one
	logic r_last;
	// Current beat is the final piece of its word
	logic r_next;

	// Handshakes
	logic load;
	logic accept;

	// Step sizes, one bit wider for the 2x compare
	logic [BW-1:0] step;
	logic [BW:0] step_w;
	logic [BW:0] step2_w;
	logic [BW:0] fill_w;

	// Bytes left after this beat and size of the following beat
	logic [BW-1:0] rem;
	logic [BW-1:0] next_bytes;
	logic [BW-1:0] first_bytes;

	//////////////////////////////////////////////////////////////////////
	// Handshake and commands
	//////////////////////////////////////////////////////////////////////

	// Next word may enter once the final piece of this one leaves
	assign o_s_ready = !m_valid || (i_m_ready && r_next);

	assign load = i_s_valid && o_s_ready;
	assign accept = m_valid && i_m_ready;

	assign o_load = load;
	// Last beat empties, any other beat moves up a step
	assign o_shift = accept && !m_last;
	assign o_clear = accept && m_last;

	//////////////////////////////////////////////////////////////////////
	// Beat sizing
	//////////////////////////////////////////////////////////////////////

	assign step = gear_cfg_pkg::step_bytes(i_size);
	assign step_w = {1'b0, step};
	assign step2_w = {step, 1'b0};
	assign fill_w = {1'b0, i_fill};

	// Only meaningful while fill exceeds one step
	assign rem = i_fill - step;
	assign next_bytes = (rem > step) ? step : rem;
	// First beat of a new word, short only on a partial final word
	assign first_bytes = (i_s_bytes > step) ? step : i_s_bytes;

	//////////////////////////////////////////////////////////////////////
	// Beat registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_reset || i_soft_reset)
		begin
			m_valid <= 1'b0;
			m_bytes <= '0;
			m_last <= 1'b0;
			r_last <= 1'b0;
			r_next <= 1'b1;
		end
		else if (load)
		begin
			m_valid <= 1'b1;
			m_bytes <= first_bytes;
			// Word fits in one beat
			r_next <= ({1'b0, i_s_bytes} <= step_w);
			m_last <= i_s_last && ({1'b0, i_s_bytes} <= step_w);
			r_last <= i_s_last && ({1'b0, i_s_bytes} > step_w);
		end
		else if (accept)
		begin
			// Anything left beyond the beat just sent
			m_valid <= (fill_w > step_w);
			m_bytes <= next_bytes;
			// At most one more beat left in this word
			r_next <= (fill_w <= step2_w);
			m_last <= r_last && (fill_w <= step2_w);
			r_last <= r_last && (fill_w > step2_w);
		end
	end

	assign o_m_valid = m_valid;
	assign o_m_bytes = m_bytes;
	assign o_m_last = m_last;

endmodule

`default_nettype wire

// File: hdl/txgears.sv
/*
 * Transmit byte gearbox
 * Splits 64-bit stream words into 1, 2, 4 or 8 byte beats
 */

`timescale 1ns/1ps
`default_nettype none

module txgears (
	input  wire logic                          i_clk,
	input  wire logic                          i_reset,
	// Configuration
	input  wire logic                          i_soft_reset,
	input  wire gear_cfg_pkg::gear_size_t      i_size,
	// Incoming words
	input  wire logic                          i_s_valid,
	output logic                               o_s_ready,
	input  wire gear_stream_pkg::gear_beat_t   i_s_beat,
	// Outgoing beats
	output logic                               o_m_valid,
	input  wire logic                          i_m_ready,
	output gear_stream_pkg::gear_beat_t        o_m_beat
);

	// Shift register commands and state
	logic load;
	logic shift;
	logic clear;
	logic [gear_cfg_pkg::BYTES_W-1:0] fill;

	gear_shift_reg u_shift (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_soft_reset (i_soft_reset),
		.i_size       (i_size),
		.i_load       (load),
		.i_shift      (shift),
		.i_clear      (clear),
		.i_data       (i_s_beat.data),
		.i_bytes      (i_s_beat.bytes),
		.o_data       (o_m_beat.data),
		.o_fill       (fill)
	);

	gear_beat_ctrl u_ctrl (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_soft_reset (i_soft_reset),
		.i_size       (i_size),
		.i_s_valid    (i_s_valid),
		.i_s_bytes    (i_s_beat.bytes),
		.i_s_last     (i_s_beat.last),
		.i_m_ready    (i_m_ready),
		.i_fill       (fill),
		.o_s_ready    (o_s_ready),
		.o_m_valid    (o_m_valid),
		.o_m_bytes    (o_m_beat.bytes),
		.o_m_last     (o_m_beat.last),
		.o_load       (load),
		.o_shift      (shift),
		.o_clear      (clear)
	);

endmodule

`default_nettype wire

// File: verif/tb_clkgen.sv
/*
 * Testbench clock and reset
 * 8 ns clock, active-low reset held for two cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic o_clk,
	output logic o_reset
);

	initial
	begin
		o_clk = 1'b0;
		forever
			#4 o_clk = !o_clk;
	end

	// Release a little after the second edge
	initial
	begin
		o_reset = 1'b0;
		repeat (2) @(posedge o_clk);
		#1 o_reset = 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/tb_txgears.sv
/*
 * Testbench for the transmit gearbox
 * Random and directed packets in all size modes, checked beat by beat
 */

`timescale 1ns/1ps
`default_nettype none

module tb_txgears;

	localparam int CYCLE_LIMIT = 20000;

	logic i_clk;
	logic i_reset;
	logic i_soft_reset = 1'b0;
	gear_cfg_pkg::gear_size_t i_size = gear_cfg_pkg::SZ_BUS;
	logic i_s_valid = 1'b0;
	logic o_s_ready;
	gear_stream_pkg::gear_beat_t i_s_beat = '0;
	logic o_m_valid;
	logic i_m_ready = 1'b1;
	gear_stream_pkg::gear_beat_t o_m_beat;

	// Packet bytes with the first byte at index 0
	logic [7:0] pkt [0:63];
	gear_stream_pkg::gear_beat_t exp_q [$];
	logic [31:0] rng_stim = 32'h0360_c652;
	logic [31:0] rng_bp = 32'h0360_c652 ^ 32'h5a5a_0f0f;
	logic bp_en = 1'b0;
	int stim_errs = 0;
	int stim_checks = 0;
	int chk_errs = 0;
	int chk_checks = 0;
	int cycles = 0;
	int tests = 0;

	tb_clkgen u_clkgen (
		.o_clk   (i_clk),
		.o_reset (i_reset)
	);

	txgears UUT (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_soft_reset (i_soft_reset),
		.i_size       (i_size),
		.i_s_valid    (i_s_valid),
		.o_s_ready    (o_s_ready),
		.i_s_beat     (i_s_beat),
		.o_m_valid    (o_m_valid),
		.i_m_ready    (i_m_ready),
		.o_m_beat     (o_m_beat)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Cut each word into step-sized pieces with a short tail only at packet end
	function automatic void expect_beats(input int len, input gear_cfg_pkg::gear_size_t size);
		gear_stream_pkg::gear_beat_t b;
		int step;
		int nw;
		int wb;
		int off;
		int n;
		step = int'(gear_cfg_pkg::step_bytes(size));
		nw = (len + 7) / 8;
		for (int w = 0; w < nw; w++)
		begin
			wb = (w == nw - 1) ? len - 8 * w : 8;
			off = 0;
			while (off < wb)
			begin
				n = (wb - off < step) ? wb - off : step;
				b = '0;
				for (int k = 0; k < n; k++)
					b.data[63 - 8 * k -: 8] = pkt[8 * w + off + k];
				b.bytes = gear_cfg_pkg::BYTES_W'(n);
				b.last = (w == nw - 1) && (off + n == wb);
				exp_q.push_back(b);
				off = off + n;
			end
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Output checker
	//////////////////////////////////////////////////////////////////////

	gear_stream_pkg::gear_beat_t held;
	logic held_v = 1'b0;

	always @(negedge i_clk)
	begin
		gear_stream_pkg::gear_beat_t e;
		logic [63:0] mask;
		// Beat stalled last cycle must stay valid and unchanged
		if (held_v && !i_soft_reset)
		begin
			chk_checks++;
			if (!o_m_valid)
			begin
				chk_errs++;
				$display("Output beat withdrawn at %0t before it was accepted", $time);
			end
			else if (o_m_beat != held)
			begin
				chk_errs++;
				$display("Mismatch at %0t: o_m_beat held %h now %h", $time, held, o_m_beat);
			end
		end
		held_v <= o_m_valid && !i_m_ready && !i_soft_reset;
		held <= o_m_beat;
		if (o_m_valid && i_m_ready && !i_soft_reset)
		begin
			chk_checks++;
			if (exp_q.size() == 0)
			begin
				chk_errs++;
				$display("Unexpected output beat at %0t with nothing left to send", $time);
			end
			else
			begin
				e = exp_q.pop_front();
				mask = ~64'd0 << (64 - 8 * int'(e.bytes));
				if (o_m_beat.bytes != e.bytes)
				begin
					chk_errs++;
					$display("Mismatch at %0t: o_m_beat.bytes got %0d expected %0d",
						$time, o_m_beat.bytes, e.bytes);
				end
				if (o_m_beat.last != e.last)
				begin
					chk_errs++;
					$display("Mismatch at %0t: o_m_beat.last got %0b expected %0b",
						$time, o_m_beat.last, e.last);
				end
				if ((o_m_beat.data & mask) != (e.data & mask))
				begin
					chk_errs++;
					$display("Mismatch at %0t: o_m_beat.data got %h expected %h",
						$time, o_m_beat.data & mask, e.data & mask);
				end
			end
		end
	end

	// Random back-pressure on the output side
	always @(posedge i_clk)
	begin
		logic en;
		en = bp_en;
		#1;
		rng_bp = xorshift(rng_bp);
		i_m_ready <= en ? rng_bp[7] : 1'b1;
	end

	// Hang guard
	always @(posedge i_clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic fill_packet(input int len);
		for (int i = 0; i < 64; i++)
		begin
			rng_stim = xorshift(rng_stim);
			pkt[i] = (i < len) ? rng_stim[7:0] : 8'h00;
		end
	endtask

	// Send one input word and wait for its handshake
	task automatic send_word(input int len, input int w);
		gear_stream_pkg::gear_beat_t b;
		int nw;
		logic took;
		nw = (len + 7) / 8;
		b = '0;
		for (int k = 0; k < 8; k++)
			b.data[63 - 8 * k -: 8] = pkt[8 * w + k];
		b.bytes = gear_cfg_pkg::BYTES_W'((w == nw - 1) ? len - 8 * w : 8);
		b.last = (w == nw - 1);
		i_s_beat = b;
		i_s_valid = 1'b1;
		took = 1'b0;
		while (!took)
		begin
			@(negedge i_clk);
			took = o_s_ready;
			@(posedge i_clk);
			#1;
		end
		i_s_valid = 1'b0;
	endtask

	task automatic send_packet(input int len, input gear_cfg_pkg::gear_size_t size);
		i_size = size;
		fill_packet(len);
		expect_beats(len, size);
		for (int w = 0; w < (len + 7) / 8; w++)
			send_word(len, w);
		while (exp_q.size() != 0 || o_m_valid)
			@(posedge i_clk);
		#1;
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests++;
		$display("Test %0d %s: %s", tests, name,
			(stim_errs + chk_errs == errs_before) ? "ok" : "errors");
	endtask

	initial
	begin
		int e0;
		gear_cfg_pkg::gear_size_t sz;
		wait (i_reset === 1'b1);
		@(posedge i_clk);
		#1;

		// Idle state out of reset
		e0 = stim_errs + chk_errs;
		@(negedge i_clk);
		stim_checks++;
		if (o_m_valid !== 1'b0)
		begin
			stim_errs++;
			$display("Mismatch at %0t: o_m_valid got %b expected 0", $time, o_m_valid);
		end
		if (o_s_ready !== 1'b1)
		begin
			stim_errs++;
			$display("Mismatch at %0t: o_s_ready got %b expected 1", $time, o_s_ready);
		end
		@(posedge i_clk);
		#1;
		end_test("reset state", e0);

		e0 = stim_errs + chk_errs;
		send_packet(20, gear_cfg_pkg::SZ_BUS);
		send_packet(23, gear_cfg_pkg::SZ_BUS);
		end_test("whole word", e0);

		e0 = stim_errs + chk_errs;
		send_packet(13, gear_cfg_pkg::SZ_BYTE);
		end_test("byte mode", e0);

		e0 = stim_errs + chk_errs;
		send_packet(11, gear_cfg_pkg::SZ_16B);
		send_packet(21, gear_cfg_pkg::SZ_16B);
		send_packet(13, gear_cfg_pkg::SZ_32B);
		send_packet(23, gear_cfg_pkg::SZ_32B);
		end_test("odd tails", e0);

		e0 = stim_errs + chk_errs;
		bp_en = 1'b1;
		for (int p = 0; p < 40; p++)
		begin
			rng_stim = xorshift(rng_stim);
			sz = gear_cfg_pkg::gear_size_t'(rng_stim[1:0]);
			send_packet(1 + int'(rng_stim[15:8]) % 40, sz);
		end
		bp_en = 1'b0;
		end_test("random with back-pressure", e0);

		// Soft reset while the first word is still unwinding
		e0 = stim_errs + chk_errs;
		i_size = gear_cfg_pkg::SZ_BYTE;
		fill_packet(16);
		expect_beats(16, gear_cfg_pkg::SZ_BYTE);
		send_word(16, 0);
		repeat (2) @(posedge i_clk);
		#1;
		i_soft_reset = 1'b1;
		@(posedge i_clk);
		#1;
		i_soft_reset = 1'b0;
		exp_q.delete();
		stim_checks++;
		if (o_m_valid !== 1'b0)
		begin
			stim_errs++;
			$display("Mismatch at %0t: o_m_valid got %b expected 0", $time, o_m_valid);
		end
		if (o_s_ready !== 1'b1)
		begin
			stim_errs++;
			$display("Mismatch at %0t: o_s_ready got %b expected 1", $time, o_s_ready);
		end
		send_packet(9, gear_cfg_pkg::SZ_16B);
		end_test("soft reset", e0);

		$display("Tests %0d, checks %0d, errors %0d", tests,
			stim_checks + chk_checks, stim_errs + chk_errs);
		if (stim_errs + chk_errs == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
hdl/gear_cfg_pkg.sv
hdl/gear_stream_pkg.sv
hdl/gear_shift_reg.sv
hdl/gear_beat_ctrl.sv
hdl/txgears.sv
verif/tb_clkgen.sv
verif/tb_txgears.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_txgears
FLIST     ?= flist.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
